/* hw/alu_unit.sv */
`default_nettype none
`timescale 1ns/1ps

module alu_unit #(
  parameter int ROB_IDX_W = 3
) (
  input  logic                 clock,
  input  logic                 rst,
  input  logic                 dispatch,
  input  isa_pkg::opcode_e     op,
  input  isa_pkg::word_t       op_a,
  input  isa_pkg::word_t       op_b,
  input  logic [ROB_IDX_W-1:0] rob_idx,
  output logic                 ready,
  cmpl_if.unit                 cmpl
);
  import isa_pkg::*;

  word_t                result;
  logic                 full_q;
  word_t                value_q;
  logic [ROB_IDX_W-1:0] idx_q;

  always_comb begin
    case (op)
      OP_SUB:  result = op_a - op_b;
      OP_AND:  result = op_a & op_b;
      OP_OR:   result = op_a | op_b;
      OP_XOR:  result = op_a ^ op_b;
      OP_SHL:  result = op_a << op_b[4:0];
      OP_LI:   result = op_b;
      default: result = op_a + op_b;
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      full_q <= 1'b0;
    end else if (dispatch) begin
      full_q <= 1'b1;
    end else if (cmpl.grant) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (dispatch) begin
      value_q <= result;
      idx_q   <= rob_idx;
    end
  end

  // A granted result frees the slot in the same cycle
  assign ready = !full_q || cmpl.grant;

  assign cmpl.req     = full_q;
  assign cmpl.rob_idx = idx_q;
  assign cmpl.value   = value_q;

endmodule

`default_nettype wire

/* hw/cmpl_arbiter.sv */
`default_nettype none
`timescale 1ns/1ps

module cmpl_arbiter #(
  parameter int ROB_IDX_W = 3
) (
  cmpl_if.arb                  alu_cmpl,
  cmpl_if.arb                  mul_cmpl,
  output logic                 wr_valid,
  output logic [ROB_IDX_W-1:0] wr_idx,
  output isa_pkg::word_t       wr_value
);

  // Multiplier first, it holds its unit longer
  assign mul_cmpl.grant = mul_cmpl.req;
  assign alu_cmpl.grant = alu_cmpl.req && !mul_cmpl.req;

  assign wr_valid = mul_cmpl.req || alu_cmpl.req;

  always_comb begin
    if (mul_cmpl.req) begin
      wr_idx   = mul_cmpl.rob_idx;
      wr_value = mul_cmpl.value;
    end else begin
      wr_idx   = alu_cmpl.rob_idx;
      wr_value = alu_cmpl.value;
    end
  end

endmodule

`default_nettype wire

/* hw/cmpl_if.sv */
`default_nettype none
`timescale 1ns/1ps

interface cmpl_if #(
  parameter int ROB_IDX_W = 3
);
  import isa_pkg::*;

  logic                 req;
  logic [ROB_IDX_W-1:0] rob_idx;
  word_t                value;
  logic                 grant;

  // req, rob_idx and value stay stable until grant
  modport unit (
    output req,
    output rob_idx,
    output value,
    input  grant
  );

  modport arb (
    input  req,
    input  rob_idx,
    input  value,
    output grant
  );

endinterface

`default_nettype wire

/* hw/isa_pkg.sv */
`default_nettype none

package isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  reg_idx_t;
  typedef logic [31:0] inst_word_t;
  typedef logic [15:0] imm_t;

  localparam int NUM_REGS = 16;

  // Field positions inside inst_word_t
  localparam int OPCODE_LSB = 28;
  localparam int RD_LSB     = 24;
  localparam int RS1_LSB    = 20;
  localparam int RS2_LSB    = 16;
  localparam int IMM_LSB    = 0;

  typedef enum logic [3:0] {
    OP_ADD = 4'd0,
    OP_SUB = 4'd1,
    OP_AND = 4'd2,
    OP_OR  = 4'd3,
    OP_XOR = 4'd4,
    OP_SHL = 4'd5,
    OP_LI  = 4'd6,
    OP_MUL = 4'd7
  } opcode_e;

endpackage

`default_nettype wire

/* hw/issue_stage.sv */
`default_nettype none
`timescale 1ns/1ps

module issue_stage #(
  parameter int ROB_IDX_W = 3
) (
  input  logic                          clock,
  input  logic                          rst,
  input  logic                          in_valid,
  input  isa_pkg::inst_word_t           in_inst,
  output logic                          in_ready,
  output logic                          alu_dispatch,
  output logic                          mul_dispatch,
  output isa_pkg::opcode_e              op,
  output isa_pkg::word_t                op_a,
  output isa_pkg::word_t                op_b,
  output logic [ROB_IDX_W-1:0]          rob_idx,
  input  logic                          alu_ready,
  input  logic                          mul_ready,
  output logic                          alloc,
  output isa_pkg::reg_idx_t             alloc_rd,
  input  logic [ROB_IDX_W-1:0]          alloc_idx,
  input  logic                          rob_full,
  input  logic [isa_pkg::NUM_REGS-1:0]  pending_mask,
  input  logic                          retire_valid,
  input  isa_pkg::reg_idx_t             retire_rd,
  input  isa_pkg::word_t                retire_value
);
  import isa_pkg::*;
  import uarch_pkg::*;

  word_t    regs_q [NUM_REGS];
  logic [3:0] raw_op;
  opcode_e  dec_op;
  reg_idx_t rd;
  reg_idx_t rs1;
  reg_idx_t rs2;
  imm_t     imm;
  unit_e    unit_sel;
  logic     reads_rs;
  logic     hazard;
  logic     unit_ready;
  logic     accept;

  assign raw_op = in_inst[OPCODE_LSB +: 4];
  assign rd     = in_inst[RD_LSB +: $bits(reg_idx_t)];
  assign rs1    = in_inst[RS1_LSB +: $bits(reg_idx_t)];
  assign rs2    = in_inst[RS2_LSB +: $bits(reg_idx_t)];
  assign imm    = in_inst[IMM_LSB +: $bits(imm_t)];

  // Unknown codes decode as add
  always_comb begin
    case (raw_op)
      OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_LI, OP_MUL: dec_op = opcode_e'(raw_op);
      default: dec_op = OP_ADD;
    endcase
  end

  assign unit_sel = (dec_op == OP_MUL) ? UNIT_MUL : UNIT_ALU;

  // Only OP_LI leaves both source fields unread
  assign reads_rs   = (dec_op != OP_LI);
  assign hazard     = reads_rs && (pending_mask[rs1] || pending_mask[rs2]);
  assign unit_ready = (unit_sel == UNIT_MUL) ? mul_ready : alu_ready;

  assign in_ready = !rob_full && !hazard && unit_ready;
  assign accept   = in_valid && in_ready;

  assign alu_dispatch = accept && (unit_sel == UNIT_ALU);
  assign mul_dispatch = accept && (unit_sel == UNIT_MUL);
  assign alloc        = accept;
  assign alloc_rd     = rd;
  assign rob_idx      = alloc_idx;

  assign op   = dec_op;
  assign op_a = regs_q[rs1];
  assign op_b = (dec_op == OP_LI) ? word_t'(imm) : regs_q[rs2];

  // Architectural state, written only at retirement
  always_ff @(posedge clock) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (retire_valid) begin
      regs_q[retire_rd] <= retire_value;
    end
  end

endmodule

`default_nettype wire

/* hw/mul_unit.sv */
`default_nettype none
`timescale 1ns/1ps

module mul_unit #(
  parameter int ROB_IDX_W   = 3,
  parameter int MUL_LATENCY = 4
) (
  input  logic                 clock,
  input  logic                 rst,
  input  logic                 dispatch,
  input  isa_pkg::word_t       op_a,
  input  isa_pkg::word_t       op_b,
  input  logic [ROB_IDX_W-1:0] rob_idx,
  output logic                 ready,
  cmpl_if.unit                 cmpl
);
  import isa_pkg::*;
  import uarch_pkg::*;

  localparam int CNT_W = $clog2(MUL_LATENCY);
  // Busy for MUL_LATENCY-1 cycles, so req rises MUL_LATENCY cycles after dispatch
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(MUL_LATENCY - 2);

  mul_state_e           state_q;
  logic [CNT_W-1:0]     cnt_q;
  logic                 last_step;
  word_t                a_q;
  word_t                b_q;
  word_t                prod_q;
  logic [ROB_IDX_W-1:0] idx_q;

  assign last_step = (state_q == MUL_BUSY) && (cnt_q == LAST_CNT);

  always_ff @(posedge clock) begin
    if (rst) begin
      state_q <= MUL_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        MUL_IDLE: begin
          if (dispatch) begin
            state_q <= MUL_BUSY;
            cnt_q   <= '0;
          end
        end
        MUL_BUSY: begin
          if (last_step) begin
            state_q <= MUL_DONE;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        MUL_DONE: begin
          if (cmpl.grant) begin
            state_q <= MUL_IDLE;
          end
        end
        default: state_q <= MUL_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state_q == MUL_IDLE && dispatch) begin
      a_q   <= op_a;
      b_q   <= op_b;
      idx_q <= rob_idx;
    end
    // Low word of the product only
    if (last_step) begin
      prod_q <= a_q * b_q;
    end
  end

  assign ready        = (state_q == MUL_IDLE);
  assign cmpl.req     = (state_q == MUL_DONE);
  assign cmpl.rob_idx = idx_q;
  assign cmpl.value   = prod_q;

endmodule

`default_nettype wire

/* hw/ooo_core.sv */
`default_nettype none
`timescale 1ns/1ps

module ooo_core #(
  parameter int ROB_DEPTH   = 8,
  parameter int MUL_LATENCY = 4
) (
  input  logic                clock,
  input  logic                rst,
  input  logic                in_valid,
  input  isa_pkg::inst_word_t in_inst,
  output logic                in_ready,
  output logic                retire_valid,
  output isa_pkg::reg_idx_t   retire_rd,
  output isa_pkg::word_t      retire_value
);
  import isa_pkg::*;

  localparam int ROB_IDX_W = $clog2(ROB_DEPTH);

  // Dispatch
  logic                 alu_dispatch;
  logic                 mul_dispatch;
  opcode_e              op;
  word_t                op_a;
  word_t                op_b;
  logic [ROB_IDX_W-1:0] rob_idx;
  logic                 alu_ready;
  logic                 mul_ready;

  // ROB allocation and write port
  logic                 alloc;
  reg_idx_t             alloc_rd;
  logic [ROB_IDX_W-1:0] alloc_idx;
  logic                 rob_full;
  logic [NUM_REGS-1:0]  pending_mask;
  logic                 wr_valid;
  logic [ROB_IDX_W-1:0] wr_idx;
  word_t                wr_value;

  cmpl_if #(.ROB_IDX_W(ROB_IDX_W)) alu_cmpl ();
  cmpl_if #(.ROB_IDX_W(ROB_IDX_W)) mul_cmpl ();

  issue_stage #(
    .ROB_IDX_W(ROB_IDX_W)
  ) u_issue_stage (
    .clock        (clock),
    .rst          (rst),
    .in_valid     (in_valid),
    .in_inst      (in_inst),
    .in_ready     (in_ready),
    .alu_dispatch (alu_dispatch),
    .mul_dispatch (mul_dispatch),
    .op           (op),
    .op_a         (op_a),
    .op_b         (op_b),
    .rob_idx      (rob_idx),
    .alu_ready    (alu_ready),
    .mul_ready    (mul_ready),
    .alloc        (alloc),
    .alloc_rd     (alloc_rd),
    .alloc_idx    (alloc_idx),
    .rob_full     (rob_full),
    .pending_mask (pending_mask),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_value (retire_value)
  );

  alu_unit #(
    .ROB_IDX_W(ROB_IDX_W)
  ) u_alu_unit (
    .clock    (clock),
    .rst      (rst),
    .dispatch (alu_dispatch),
    .op       (op),
    .op_a     (op_a),
    .op_b     (op_b),
    .rob_idx  (rob_idx),
    .ready    (alu_ready),
    .cmpl     (alu_cmpl)
  );

  mul_unit #(
    .ROB_IDX_W   (ROB_IDX_W),
    .MUL_LATENCY (MUL_LATENCY)
  ) u_mul_unit (
    .clock    (clock),
    .rst      (rst),
    .dispatch (mul_dispatch),
    .op_a     (op_a),
    .op_b     (op_b),
    .rob_idx  (rob_idx),
    .ready    (mul_ready),
    .cmpl     (mul_cmpl)
  );

  cmpl_arbiter #(
    .ROB_IDX_W(ROB_IDX_W)
  ) u_cmpl_arbiter (
    .alu_cmpl (alu_cmpl),
    .mul_cmpl (mul_cmpl),
    .wr_valid (wr_valid),
    .wr_idx   (wr_idx),
    .wr_value (wr_value)
  );

  reorder_buffer #(
    .ROB_DEPTH (ROB_DEPTH),
    .ROB_IDX_W (ROB_IDX_W)
  ) u_reorder_buffer (
    .clock        (clock),
    .rst          (rst),
    .alloc        (alloc),
    .alloc_rd     (alloc_rd),
    .alloc_idx    (alloc_idx),
    .rob_full     (rob_full),
    .pending_mask (pending_mask),
    .wr_valid     (wr_valid),
    .wr_idx       (wr_idx),
    .wr_value     (wr_value),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_value (retire_value)
  );

endmodule

`default_nettype wire

/* hw/reorder_buffer.sv */
`default_nettype none
`timescale 1ns/1ps

module reorder_buffer #(
  parameter int ROB_DEPTH = 8,
  parameter int ROB_IDX_W = 3
) (
  input  logic                          clock,
  input  logic                          rst,
  input  logic                          alloc,
  input  isa_pkg::reg_idx_t             alloc_rd,
  output logic [ROB_IDX_W-1:0]          alloc_idx,
  output logic                          rob_full,
  output logic [isa_pkg::NUM_REGS-1:0]  pending_mask,
  input  logic                          wr_valid,
  input  logic [ROB_IDX_W-1:0]          wr_idx,
  input  isa_pkg::word_t                wr_value,
  output logic                          retire_valid,
  output isa_pkg::reg_idx_t             retire_rd,
  output isa_pkg::word_t                retire_value
);
  import isa_pkg::*;

  logic [ROB_DEPTH-1:0] valid_q;
  logic [ROB_DEPTH-1:0] done_q;
  reg_idx_t             rd_q    [ROB_DEPTH];
  word_t                value_q [ROB_DEPTH];
  logic [ROB_IDX_W-1:0] head_q;
  logic [ROB_IDX_W-1:0] tail_q;

  // Entries stay contiguous, so a live tail slot means no room left
  assign rob_full  = valid_q[tail_q];
  assign alloc_idx = tail_q;

  assign retire_valid = valid_q[head_q] && done_q[head_q];
  assign retire_rd    = rd_q[head_q];
  assign retire_value = value_q[head_q];

  always_comb begin
    pending_mask = '0;
    for (int i = 0; i < ROB_DEPTH; i++) begin
      if (valid_q[i]) begin
        pending_mask[rd_q[i]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      valid_q <= '0;
      done_q  <= '0;
      head_q  <= '0;
      tail_q  <= '0;
    end else begin
      if (retire_valid) begin
        valid_q[head_q] <= 1'b0;
        head_q          <= head_q + 1'b1;
      end
      if (alloc) begin
        valid_q[tail_q] <= 1'b1;
        done_q[tail_q]  <= 1'b0;
        tail_q          <= tail_q + 1'b1;
      end
      if (wr_valid) begin
        done_q[wr_idx] <= 1'b1;
      end
    end
  end

  // Entry payload
  always_ff @(posedge clock) begin
    if (alloc) begin
      rd_q[tail_q] <= alloc_rd;
    end
    if (wr_valid) begin
      value_q[wr_idx] <= wr_value;
    end
  end

endmodule

`default_nettype wire

/* hw/uarch_pkg.sv */
`default_nettype none

package uarch_pkg;

  // Execution unit selected at issue
  typedef enum logic {
    UNIT_ALU = 1'b0,
    UNIT_MUL = 1'b1
  } unit_e;

  typedef enum logic [1:0] {
    MUL_IDLE = 2'd0,
    MUL_BUSY = 2'd1,
    MUL_DONE = 2'd2
  } mul_state_e;

endpackage

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timing --top-module tb_ooo_core -f src.f \
  -Mdir obj_dir -o sim_ooo_core
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_ooo_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
exit 0

/* src.f */
hw/isa_pkg.sv
hw/uarch_pkg.sv
hw/cmpl_if.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/cmpl_arbiter.sv
hw/reorder_buffer.sv
hw/issue_stage.sv
hw/ooo_core.sv
test/ooo_core_props.sv
test/tb_ooo_core.sv

/* test/ooo_core_props.sv */
`default_nettype none
`timescale 1ns/1ps

module ooo_core_props (
  input logic clock,
  input logic rst,
  input logic retire_valid,
  input logic alu_req,
  input logic alu_grant,
  input logic mul_req,
  input logic mul_grant
);

  // Single ROB write port
  grant_onehot: assert property (
    @(posedge clock) disable iff (rst) !(alu_grant && mul_grant)
  ) else $error("ALU and multiplier granted in the same cycle");

  alu_grant_req: assert property (
    @(posedge clock) disable iff (rst) alu_grant |-> alu_req
  ) else $error("ALU grant without an ALU request");

  mul_grant_req: assert property (
    @(posedge clock) disable iff (rst) mul_grant |-> mul_req
  ) else $error("Multiplier grant without a multiplier request");

  // ROB comes out of reset empty
  retire_after_reset: assert property (
    @(posedge clock) rst |=> !retire_valid
  ) else $error("retire_valid high in the cycle after reset");

endmodule

bind ooo_core ooo_core_props props_i (
  .clock        (clock),
  .rst          (rst),
  .retire_valid (retire_valid),
  .alu_req      (alu_cmpl.req),
  .alu_grant    (alu_cmpl.grant),
  .mul_req      (mul_cmpl.req),
  .mul_grant    (mul_cmpl.grant)
);

`default_nettype wire

/* test/tb_ooo_core.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_ooo_core;
  import isa_pkg::*;

  localparam int ROB_DEPTH   = 4;
  localparam int MUL_LATENCY = 4;
  localparam int STREAM_LEN  = 250;
  // About 300 instructions at up to MUL_LATENCY+6 cycles each, plus margin
  localparam int MAX_CYCLES  = 300 * (MUL_LATENCY + 6) + 1000;

  logic       clock;
  logic       rst;
  logic       in_valid;
  inst_word_t in_inst;
  logic       in_ready;
  logic       retire_valid;
  reg_idx_t   retire_rd;
  word_t      retire_value;

  // Reference model state
  word_t    model_regs [NUM_REGS];
  reg_idx_t exp_rd_q   [$];
  word_t    exp_val_q  [$];
  string    exp_test_q [$];
  string    test_name;

  int accept_count = 0;
  int retire_count = 0;
  int stall_cycles = 0;
  int cycle_count  = 0;
  int value_errors = 0;
  int other_errors = 0;

  ooo_core #(
    .ROB_DEPTH   (ROB_DEPTH),
    .MUL_LATENCY (MUL_LATENCY)
  ) dut_i (
    .clock        (clock),
    .rst          (rst),
    .in_valid     (in_valid),
    .in_inst      (in_inst),
    .in_ready     (in_ready),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_value (retire_value)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  function automatic inst_word_t make_inst(logic [3:0] opc, reg_idx_t rd, reg_idx_t rs1,
                                           reg_idx_t rs2, logic [15:0] imm);
    return {opc, rd, rs1, rs2, imm};
  endfunction

  // Result from the ISA rules and the model registers
  function automatic word_t model_result(inst_word_t inst);
    word_t a;
    word_t b;
    word_t r;
    a = model_regs[inst[23:20]];
    b = model_regs[inst[19:16]];
    case (inst[31:28])
      OP_SUB:  r = a - b;
      OP_AND:  r = a & b;
      OP_OR:   r = a | b;
      OP_XOR:  r = a ^ b;
      OP_SHL:  r = a << b[4:0];
      OP_LI:   r = {16'h0000, inst[15:0]};
      OP_MUL:  r = a * b;
      default: r = a + b;
    endcase
    return r;
  endfunction

  task automatic check_retire();
    reg_idx_t exp_rd;
    word_t    exp_val;
    string    name;
    assert (exp_rd_q.size() > 0) else begin
      other_errors++;
      $display("Retirement of r%0d with no accepted instruction outstanding", retire_rd);
    end
    if (exp_rd_q.size() > 0) begin
      exp_rd  = exp_rd_q.pop_front();
      exp_val = exp_val_q.pop_front();
      name    = exp_test_q.pop_front();
      assert (retire_rd == exp_rd) else begin
        value_errors++;
        $display("FAILED %s: retire_rd expected %0d actual %0d", name, exp_rd, retire_rd);
      end
      assert (retire_value == exp_val) else begin
        value_errors++;
        $display("FAILED %s: retire_value expected %h actual %h", name, exp_val,
                 retire_value);
      end
      retire_count++;
    end
  endtask

  // Acceptance and retirement monitor
  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles with %0d retirements outstanding",
               cycle_count, accept_count - retire_count);
      $display("ERRORS FOUND");
      $finish;
    end else if (!rst) begin
      if (in_valid && in_ready) begin
        exp_rd_q.push_back(in_inst[27:24]);
        exp_val_q.push_back(model_result(in_inst));
        exp_test_q.push_back(test_name);
        // Model registers follow program order
        model_regs[in_inst[27:24]] = exp_val_q[$];
        accept_count++;
      end else if (in_valid) begin
        stall_cycles++;
      end
      if (retire_valid) begin
        check_retire();
      end
    end
  end

  // Holds the instruction until accepted, leaves in_valid high
  task automatic send(inst_word_t inst);
    int start;
    start    = accept_count;
    in_valid = 1'b1;
    in_inst  = inst;
    do begin
      @(negedge clock);
    end while (accept_count == start);
  endtask

  task automatic drain();
    in_valid = 1'b0;
    while (retire_count != accept_count) begin
      @(negedge clock);
    end
  endtask

  initial begin
    int stalls_before;
    void'($urandom(32'h72e2903b));
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_inst   = '0;
    test_name = "reset";
    repeat (3) @(negedge clock);
    rst = 1'b0;
    // Idle cycles with nothing to retire
    repeat (4) @(negedge clock);
    send(make_inst(OP_ADD, 4'd8, 4'd9, 4'd10, 16'h0000));
    send(make_inst(OP_LI, 4'd1, 4'd0, 4'd0, 16'h1234));
    send(make_inst(OP_LI, 4'd2, 4'd0, 4'd0, 16'hffff));
    send(make_inst(OP_LI, 4'd3, 4'd0, 4'd0, 16'h0025));
    send(make_inst(OP_LI, 4'd4, 4'd0, 4'd0, 16'h8001));
    drain();

    test_name = "alu_ops";
    send(make_inst(OP_ADD, 4'd5, 4'd1, 4'd2, 16'h0000));
    send(make_inst(OP_SUB, 4'd6, 4'd1, 4'd2, 16'h0000));
    send(make_inst(OP_AND, 4'd7, 4'd2, 4'd4, 16'h0000));
    send(make_inst(OP_OR, 4'd8, 4'd1, 4'd4, 16'h0000));
    send(make_inst(OP_XOR, 4'd9, 4'd2, 4'd1, 16'h0000));
    // Shift amount 37 uses only its low 5 bits
    send(make_inst(OP_SHL, 4'd10, 4'd4, 4'd3, 16'h0000));
    send(make_inst(4'hc, 4'd11, 4'd1, 4'd1, 16'h0000));
    drain();

    test_name = "mul_ooo";
    send(make_inst(OP_MUL, 4'd12, 4'd10, 4'd2, 16'h0000));
    send(make_inst(OP_ADD, 4'd13, 4'd1, 4'd3, 16'h0000));
    send(make_inst(OP_XOR, 4'd14, 4'd2, 4'd4, 16'h0000));
    send(make_inst(OP_SUB, 4'd15, 4'd3, 4'd1, 16'h0000));
    drain();

    test_name = "dep_chain";
    send(make_inst(OP_LI, 4'd1, 4'd0, 4'd0, 16'h0003));
    send(make_inst(OP_MUL, 4'd2, 4'd1, 4'd1, 16'h0000));
    send(make_inst(OP_ADD, 4'd3, 4'd2, 4'd1, 16'h0000));
    send(make_inst(OP_MUL, 4'd4, 4'd3, 4'd3, 16'h0000));
    send(make_inst(OP_SHL, 4'd5, 4'd4, 4'd1, 16'h0000));
    send(make_inst(OP_MUL, 4'd6, 4'd5, 4'd5, 16'h0000));
    send(make_inst(OP_XOR, 4'd7, 4'd6, 4'd4, 16'h0000));
    send(make_inst(OP_SUB, 4'd1, 4'd7, 4'd2, 16'h0000));
    drain();

    test_name     = "backpressure";
    stalls_before = stall_cycles;
    for (int n = 0; n < STREAM_LEN; n++) begin
      send(make_inst(4'($urandom_range(0, 9)), reg_idx_t'($urandom_range(0, 15)),
                     reg_idx_t'($urandom_range(0, 15)), reg_idx_t'($urandom_range(0, 15)),
                     16'($urandom())));
    end
    drain();
    assert (stall_cycles > stalls_before) else begin
      other_errors++;
      $display("in_ready never dropped during the random stream");
    end

    // Late extra retirements still reach the monitor
    repeat (3) @(negedge clock);
    $display("Value errors: %0d, other errors: %0d, accepted %0d, retired %0d",
             value_errors, other_errors, accept_count, retire_count);
    if (value_errors + other_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire
